/* verification/sha256_golden.txt */
# Each vector: kind ctrl wntz / block words 0-7 / block words 8-15 / expected digest
# Kind 1 single block, 5 first block unchecked, 2 next block, 3 chain, 4 error case
# Chain rows carry a zero digest; their result comes from the reference model
1 00000005 00000000
61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018
ba7816bf 8f01cfea 414140de 5dae2223 b00361a3 96177a9c b410ff61 f20015ad
1 00000001 00000000
61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018
23097d22 3405d822 8642a477 bda255b3 2aadbce4 bda0b3f7 e36c9da7 00000000
5 00000005 00000000
61626364 62636465 63646566 64656667 65666768 66676869 6768696a 68696a6b
696a6b6c 6a6b6c6d 6b6c6d6e 6c6d6e6f 6d6e6f70 6e6f7071 80000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2 00000006 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 000001c0
248d6a61 d20638b8 e5c02693 0c3e6039 a33ce459 64ff2167 f6ecedd4 19db06c1
3 00000215 00010007
00112233 44556677 8899aabb ccddeeff 0000002a 00000000 00000000 00000000
0f1e2d3c 4b5a6978 8796a5b4 c3d2e1f0 01234567 89abcdef fedcba98 76543210
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
3 00000115 00000003
a5a5a5a5 5a5a5a5a 13579bdf 2468ace0 00000011 00000000 00000000 00000000
deadbeef cafef00d 31415926 27182818 00000001 00000002 00000003 00000004
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
4 00000315 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
4 00000215 00050000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
4 00000007 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

/* vlog.f */
+incdir+include
logic/sha256_pkg.sv
logic/sha256_regs.sv
logic/sha256_chain_ctrl.sv
logic/sha256_core.sv
logic/sha256_top.sv
verification/tb_sha256.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_sha256
FLAGS ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f vlog.f
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* verification/tb_sha256.sv */
// SHA-256 accelerator testbench
`timescale 1ns/1ps

module tb_sha256;

  logic        clk;
  logic        reset_n;
  logic        cs;
  logic        we;
  logic [5:0]  address;
  logic [31:0] write_data;
  logic [31:0] read_data;
  logic        err;
  logic [31:0] lfsr_q;

  // Round constants for the reference model from FIPS 180-4
  localparam logic [31:0] k_tab [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };
  localparam sha256_pkg::sha256_digest_t iv256 = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };
  localparam sha256_pkg::sha256_digest_t iv224 = {
    32'hc1059ed8, 32'h367cd507, 32'h3070dd17, 32'hf70e5939,
    32'hffc00b31, 32'h68581511, 32'h64f98fa7, 32'hbefa4fa4
  };

  sha256_top dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .err        (err)
  );

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // --------------------
  // Reference SHA-256 compression
  function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic sha256_pkg::sha256_digest_t compress(
      input sha256_pkg::sha256_digest_t h, input sha256_pkg::sha256_block_t m);
    logic [31:0] w [64];
    logic [31:0] v [8];
    logic [31:0] s0;
    logic [31:0] s1;
    logic [31:0] t1;
    logic [31:0] t2;
    sha256_pkg::sha256_digest_t r;
    for (int t = 0; t < 64; t++) begin
      if (t < 16) begin
        w[t] = m[t];
      end else begin
        s0   = rotr(w[t-15], 7) ^ rotr(w[t-15], 18) ^ (w[t-15] >> 3);
        s1   = rotr(w[t-2], 17) ^ rotr(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = w[t-16] + s0 + w[t-7] + s1;
      end
    end
    for (int i = 0; i < 8; i++) v[i] = h[i];
    for (int t = 0; t < 64; t++) begin
      s1 = rotr(v[4], 6) ^ rotr(v[4], 11) ^ rotr(v[4], 25);
      t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + k_tab[t] + w[t];
      s0 = rotr(v[0], 2) ^ rotr(v[0], 13) ^ rotr(v[0], 22);
      t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      // Shift a..h down one place
      for (int i = 7; i > 0; i--) v[i] = v[i-1];
      v[4] = v[4] + t1;
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) r[i] = h[i] + v[i];
    return r;
  endfunction

  // Chain of blocks I q i j prev padded to 440 bits
  function automatic sha256_pkg::sha256_digest_t chain_model(
      input sha256_pkg::sha256_block_t blk, input logic [31:0] ctrl_w,
      input logic [31:0] wz_w);
    int last;
    sha256_pkg::sha256_digest_t prev;
    sha256_pkg::sha256_block_t m;
    last = (1 << ctrl_w[11:8]) - 1;
    prev = blk[8:15];
    for (int j = int'(wz_w[23:16]); j <= last; j++) begin
      m    = {blk[0:4], wz_w[15:0], 8'(j), prev, 8'h80, 64'd440};
      prev = compress(iv256, m);
    end
    return prev;
  endfunction

  // --------------------
  // Fibonacci LFSR with one bit per step
  function logic lfsr_step();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  task idle_gap();
    int n;
    n = int'(lfsr_step());
    n = n * 2 + int'(lfsr_step());
    repeat (n) @(negedge clk);
  endtask

  // --------------------
  // Compare tasks
  task fail_now();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
      fail_now();
    end
  endtask

  task check_status(input sha256_pkg::sha256_status_t got,
                    input sha256_pkg::sha256_status_t exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s status got %b expected %b", $time, what, got, exp);
      fail_now();
    end
  endtask

  task check_digest(input sha256_pkg::sha256_digest_t got,
                    input sha256_pkg::sha256_digest_t exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s digest got %h expected %h", $time, what, got, exp);
      fail_now();
    end
  endtask

  // --------------------
  // Bus access with err and read_data sampled one cycle later
  task bus_write(input logic [5:0] a, input logic [31:0] d, output logic e);
    idle_gap();
    @(negedge clk);
    cs         = 1'b1;
    we         = 1'b1;
    address    = a;
    write_data = d;
    @(negedge clk);
    e  = err;
    cs = 1'b0;
    we = 1'b0;
  endtask

  task bus_read(input logic [5:0] a, output logic [31:0] d, output logic e);
    idle_gap();
    @(negedge clk);
    cs      = 1'b1;
    we      = 1'b0;
    address = a;
    @(negedge clk);
    d  = read_data;
    e  = err;
    cs = 1'b0;
  endtask

  task write_ok(input logic [5:0] a, input logic [31:0] d);
    logic e;
    bus_write(a, d, e);
    check_word({31'b0, e}, 32'd0, "err on legal write");
  endtask

  task read_ok(input logic [5:0] a, output logic [31:0] d);
    logic e;
    bus_read(a, d, e);
    check_word({31'b0, e}, 32'd0, "err on legal read");
  endtask

  task read_status(output sha256_pkg::sha256_status_t s);
    logic [31:0] w;
    read_ok(sha256_pkg::addr_status, w);
    s = sha256_pkg::sha256_status_t'(w[3:0]);
  endtask

  task read_digest(output sha256_pkg::sha256_digest_t d);
    for (int k = 0; k < 8; k++) begin
      read_ok(sha256_pkg::addr_digest_base + 6'(k), d[k]);
    end
  endtask

  // Poll for valid while not busy or for the error bit
  task wait_for(input bit want_error, output logic saw_busy);
    sha256_pkg::sha256_status_t s;
    logic hit;
    hit      = 1'b0;
    saw_busy = 1'b0;
    for (int n = 0; n < 2000 && !hit; n++) begin
      read_status(s);
      if (s.wntz_busy) saw_busy = 1'b1;
      hit = want_error ? s.error : (s.valid & ~s.wntz_busy);
    end
    if (!hit) begin
      $display("Timeout while polling the status register");
      fail_now();
    end
  endtask

  task zeroize_and_check();
    sha256_pkg::sha256_status_t s;
    write_ok(sha256_pkg::addr_ctrl, 32'h8);
    read_status(s);
    check_status(s, sha256_pkg::sha256_status_t'(4'b0001), "after zeroize");
  endtask

  // Next data line skipping comments and blank lines
  task next_line(input int fd, output string line);
    int ok;
    line = "";
    while (line.len() < 3 || line.getc(0) == 8'h23) begin
      ok = $fgets(line, fd);
      if (ok == 0) begin
        line = "";
        return;
      end
    end
  endtask

  // --------------------
  // One golden vector
  task run_vector(input int kind, input logic [31:0] ctrl_w, input logic [31:0] wz_w,
                  input sha256_pkg::sha256_block_t blk,
                  input sha256_pkg::sha256_digest_t exp);
    sha256_pkg::sha256_digest_t got;
    sha256_pkg::sha256_digest_t model;
    sha256_pkg::sha256_status_t s;
    logic saw_busy;
    if (kind == 4) begin
      write_ok(sha256_pkg::addr_wntz, wz_w);
      write_ok(sha256_pkg::addr_ctrl, ctrl_w);
      wait_for(1'b1, saw_busy);
      zeroize_and_check();
      return;
    end
    for (int k = 0; k < 16; k++) write_ok(6'(k), blk[k]);
    if (kind == 3) write_ok(sha256_pkg::addr_wntz, wz_w);
    write_ok(sha256_pkg::addr_ctrl, ctrl_w);
    wait_for(1'b0, saw_busy);
    read_status(s);
    check_status(s, sha256_pkg::sha256_status_t'(4'b0011), "after hash");
    if (kind == 5) return;
    read_digest(got);
    if (kind == 3) begin
      check_word({31'b0, saw_busy}, 32'd1, "wntz_busy seen during chain");
      check_digest(got, chain_model(blk, ctrl_w, wz_w), "chain");
    end else begin
      check_digest(got, exp, "host hash");
    end
    // Single blocks also cross-check the reference model
    if (kind == 1) begin
      model = compress(ctrl_w[2] ? iv256 : iv224, blk);
      if (!ctrl_w[2]) model[7] = '0;
      check_digest(model, exp, "reference model");
    end
  endtask

  // --------------------
  // Main sequence
  initial begin
    int fd;
    int kind;
    int cnt;
    string line;
    logic [31:0] ctrl_w;
    logic [31:0] wz_w;
    logic [31:0] w;
    logic e;
    sha256_pkg::sha256_block_t blk;
    sha256_pkg::sha256_digest_t exp;
    sha256_pkg::sha256_digest_t got;
    sha256_pkg::sha256_status_t s;

    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    reset_n    = 1'b0;
    lfsr_q     = 32'h6445;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Reset values
    read_status(s);
    check_status(s, sha256_pkg::sha256_status_t'(4'b0001), "after reset");
    read_digest(got);
    check_digest(got, '0, "after reset");

    fd = $fopen("verification/sha256_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden vector file");
      fail_now();
    end
    next_line(fd, line);
    while (line.len() > 0) begin
      // Header row then two block rows and the digest row
      cnt = $sscanf(line, "%h %h %h", kind, ctrl_w, wz_w);
      next_line(fd, line);
      cnt += $sscanf(line, "%h %h %h %h %h %h %h %h", blk[0], blk[1], blk[2], blk[3],
                     blk[4], blk[5], blk[6], blk[7]);
      next_line(fd, line);
      cnt += $sscanf(line, "%h %h %h %h %h %h %h %h", blk[8], blk[9], blk[10], blk[11],
                     blk[12], blk[13], blk[14], blk[15]);
      next_line(fd, line);
      cnt += $sscanf(line, "%h %h %h %h %h %h %h %h", exp[0], exp[1], exp[2], exp[3],
                     exp[4], exp[5], exp[6], exp[7]);
      if (cnt != 27) begin
        $display("Malformed vector in the golden file");
        fail_now();
      end
      run_vector(kind, ctrl_w, wz_w, blk, exp);
      next_line(fd, line);
    end
    $fclose(fd);

    // Hash one more block so digest and block hold data
    for (int k = 0; k < 16; k++) begin
      write_ok(6'(k), 32'h1000_0000 | 32'(k + 1));
    end
    write_ok(sha256_pkg::addr_ctrl, 32'h5);
    wait_for(1'b0, e);

    // Zeroize wipes digest and block
    zeroize_and_check();
    read_digest(got);
    check_digest(got, '0, "after zeroize");
    for (int k = 0; k < 16; k++) begin
      read_ok(6'(k), w);
      check_word(w, 32'd0, "block word after zeroize");
    end

    // Unmapped read
    bus_read(6'h13, w, e);
    check_word({31'b0, e}, 32'd1, "err after unmapped read");
    wait_for(1'b1, e);
    zeroize_and_check();

    // Write to the read only status word
    bus_write(sha256_pkg::addr_status, 32'hf, e);
    check_word({31'b0, e}, 32'd1, "err after status write");
    wait_for(1'b1, e);
    zeroize_and_check();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* logic/sha256_top.sv */
// SHA-256 accelerator top level
`timescale 1ns/1ps

module sha256_top (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              cs,
  input  logic                              we,
  input  logic [sha256_pkg::addr_width-1:0] address,
  input  logic [31:0]                       write_data,
  output logic [31:0]                       read_data,
  output logic                              err
);

  sha256_pkg::sha256_ctrl_t     ctrl;
  sha256_pkg::sha256_wntz_t     wntz;
  sha256_pkg::sha256_block_t    block;
  sha256_pkg::sha256_status_t   status;
  sha256_pkg::sha256_digest_t   digest;
  sha256_pkg::sha256_core_req_t core_req;
  sha256_pkg::sha256_core_rsp_t core_rsp;

  // --------------------
  // Bus side registers
  sha256_regs u_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .err        (err),
    .ctrl       (ctrl),
    .wntz       (wntz),
    .block      (block),
    .status     (status),
    .digest     (digest)
  );

  // Host pass through or chain block builder
  sha256_chain_ctrl u_chain (
    .clk      (clk),
    .reset_n  (reset_n),
    .ctrl     (ctrl),
    .wntz     (wntz),
    .block    (block),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .status   (status),
    .digest   (digest)
  );

  // Compression core
  sha256_core u_core (
    .clk      (clk),
    .reset_n  (reset_n),
    .core_req (core_req),
    .core_rsp (core_rsp),
    .zeroize  (ctrl.zeroize)
  );

endmodule

/* logic/sha256_core.sv */
// SHA-256/224 compression core
`timescale 1ns/1ps

module sha256_core (
  input  logic                         clk,
  input  logic                         reset_n,
  input  sha256_pkg::sha256_core_req_t core_req,
  output sha256_pkg::sha256_core_rsp_t core_rsp,
  input  logic                         zeroize
);

  `include "sha256_k_table.svh"

  // --------------------
  // Round functions
  function automatic logic [31:0] big_sigma0(input logic [31:0] x);
    return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
  endfunction

  function automatic logic [31:0] big_sigma1(input logic [31:0] x);
    return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
  endfunction

  function automatic logic [31:0] small_sigma0(input logic [31:0] x);
    return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ {3'b000, x[31:3]};
  endfunction

  function automatic logic [31:0] small_sigma1(input logic [31:0] x);
    return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ {10'b0, x[31:10]};
  endfunction

  function automatic logic [31:0] ch(input logic [31:0] e, input logic [31:0] f,
                                     input logic [31:0] g);
    return (e & f) ^ (~e & g);
  endfunction

  function automatic logic [31:0] maj(input logic [31:0] a, input logic [31:0] b,
                                      input logic [31:0] c);
    return (a & b) ^ (a & c) ^ (b & c);
  endfunction

  // Working variables a to h as words 0 to 7
  sha256_pkg::sha256_digest_t vars_q;
  sha256_pkg::sha256_digest_t hash_q;
  sha256_pkg::sha256_digest_t start_state;
  // Rolling schedule, word 0 is W[t]
  sha256_pkg::sha256_block_t  w_q;
  logic [6:0]  round_q;
  logic        busy_q;
  logic        valid_q;
  logic        accept;
  logic        last;
  logic [31:0] t1;
  logic [31:0] t2;
  logic [31:0] w_new;

  // Commands are only taken while idle
  assign accept = ~busy_q & (core_req.cmd != sha256_pkg::cmd_none);
  // Round 64 is the hash update cycle
  assign last   = busy_q & (round_q == 7'd64);

  always_comb begin
    if (core_req.cmd == sha256_pkg::cmd_init) begin
      start_state = core_req.mode ? sha256_iv : sha224_iv;
    end else begin
      start_state = hash_q;
    end
  end

  always_comb begin
    t1    = vars_q[7] + big_sigma1(vars_q[4]) + ch(vars_q[4], vars_q[5], vars_q[6])
            + sha256_k[round_q[5:0]] + w_q[0];
    t2    = big_sigma0(vars_q[0]) + maj(vars_q[0], vars_q[1], vars_q[2]);
    // W[t+16] from W[t+14], W[t+9], W[t+1] and W[t]
    w_new = small_sigma1(w_q[14]) + w_q[9] + small_sigma0(w_q[1]) + w_q[0];
  end

  // --------------------
  // Round control
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q  <= 1'b0;
      round_q <= '0;
      valid_q <= 1'b0;
    end else if (zeroize) begin
      busy_q  <= 1'b0;
      round_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (accept) begin
        busy_q  <= 1'b1;
        round_q <= '0;
      end else if (last) begin
        busy_q  <= 1'b0;
        valid_q <= 1'b1;
      end else if (busy_q) begin
        round_q <= round_q + 7'd1;
      end
    end
  end

  // --------------------
  // Data path
  always_ff @(posedge clk) begin
    if (zeroize) begin
      hash_q <= '0;
      vars_q <= '0;
      w_q    <= '0;
    end else if (accept) begin
      hash_q <= start_state;
      vars_q <= start_state;
      w_q    <= core_req.block;
    end else if (last) begin
      for (int i = 0; i < sha256_pkg::digest_words; i++) begin
        hash_q[i] <= hash_q[i] + vars_q[i];
      end
    end else if (busy_q) begin
      vars_q <= {t1 + t2, vars_q[0:2], vars_q[3] + t1, vars_q[4:6]};
      w_q    <= {w_q[1:15], w_new};
    end
  end

  assign core_rsp.ready        = ~busy_q;
  assign core_rsp.digest_valid = valid_q;
  assign core_rsp.digest       = hash_q;

endmodule

/* logic/sha256_chain_ctrl.sv */
// Winternitz chain controller
`timescale 1ns/1ps

module sha256_chain_ctrl (
  input  logic                         clk,
  input  logic                         reset_n,
  input  sha256_pkg::sha256_ctrl_t     ctrl,
  input  sha256_pkg::sha256_wntz_t     wntz,
  input  sha256_pkg::sha256_block_t    block,
  output sha256_pkg::sha256_core_req_t core_req,
  input  sha256_pkg::sha256_core_rsp_t core_rsp,
  output sha256_pkg::sha256_status_t   status,
  output sha256_pkg::sha256_digest_t   digest
);

  sha256_pkg::chain_state_e   state_q;
  sha256_pkg::sha256_digest_t prev_q;
  sha256_pkg::sha256_digest_t masked;
  // I (16 bytes), q (4 bytes) and i (2 bytes)
  logic [175:0] prefix_q;
  logic [7:0]   j_q;
  logic [7:0]   last_j_q;
  logic [7:0]   iter_max;
  logic         issue_q;
  logic         cap_mode_q;
  logic         valid_q;
  logic         error_q;
  logic         busy;
  logic         idle_ready;
  logic         cmd_any;
  logic         cmd_clash;
  logic         chain_req;
  logic         w_bad;
  logic         param_bad;
  logic         chain_go;
  logic         host_go;
  logic         error_set;
  logic         done;

  // --------------------
  // Last j is 2^w - 1
  always_comb begin
    w_bad = 1'b0;
    case (ctrl.wntz_w)
      4'd1:    iter_max = 8'd1;
      4'd2:    iter_max = 8'd3;
      4'd4:    iter_max = 8'd15;
      4'd8:    iter_max = 8'd255;
      default: begin
        iter_max = 8'd0;
        w_bad    = 1'b1;
      end
    endcase
  end

  assign busy       = state_q != sha256_pkg::chain_idle;
  assign idle_ready = core_rsp.ready & ~busy;
  assign cmd_any    = ctrl.init | ctrl.next;
  assign cmd_clash  = ctrl.init & ctrl.next;
  assign chain_req  = ctrl.init & ctrl.wntz_mode & ~ctrl.next;
  // Chains always run SHA-256
  assign param_bad  = w_bad | (wntz.j_start > iter_max) | ~ctrl.mode;
  assign chain_go   = chain_req & idle_ready & ~param_bad;
  assign host_go    = cmd_any & ~cmd_clash & ~chain_req & idle_ready;
  // Dropped or illegal commands
  assign error_set  = cmd_clash | (cmd_any & ~idle_ready) | (chain_req & param_bad);
  // Host hash, or the block with the last j
  assign done       = core_rsp.digest_valid & (~busy | (j_q == last_j_q));

  // --------------------
  // Core request, chain blocks carry I q i j prev then padding
  always_comb begin
    core_req.cmd   = sha256_pkg::cmd_none;
    core_req.mode  = ctrl.mode;
    core_req.block = block;
    if (busy) begin
      core_req.mode  = 1'b1;
      core_req.block = {prefix_q, j_q, prev_q, 8'h80, sha256_pkg::chain_msg_bits};
      if (issue_q) begin
        core_req.cmd = sha256_pkg::cmd_init;
      end
    end else if (host_go) begin
      core_req.cmd = ctrl.init ? sha256_pkg::cmd_init : sha256_pkg::cmd_next;
    end
  end

  // --------------------
  // Chain FSM, one core init per block
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q  <= sha256_pkg::chain_idle;
      issue_q  <= 1'b0;
      j_q      <= '0;
      last_j_q <= '0;
    end else if (ctrl.zeroize) begin
      state_q <= sha256_pkg::chain_idle;
      issue_q <= 1'b0;
    end else begin
      issue_q <= 1'b0;
      case (state_q)
        sha256_pkg::chain_idle: begin
          if (chain_go) begin
            j_q      <= wntz.j_start;
            last_j_q <= iter_max;
            issue_q  <= 1'b1;
            state_q  <= sha256_pkg::chain_first;
          end
        end
        sha256_pkg::chain_first, sha256_pkg::chain_others: begin
          if (core_rsp.digest_valid) begin
            if (j_q == last_j_q) begin
              state_q <= sha256_pkg::chain_idle;
            end else begin
              j_q     <= j_q + 8'd1;
              issue_q <= 1'b1;
              state_q <= sha256_pkg::chain_others;
            end
          end
        end
        default: state_q <= sha256_pkg::chain_idle;
      endcase
    end
  end

  // Chain data path, seed y comes from the host block
  always_ff @(posedge clk) begin
    if (ctrl.zeroize) begin
      prefix_q <= '0;
      prev_q   <= '0;
    end else if (chain_go) begin
      prefix_q <= {block[0:4], wntz.i};
      prev_q   <= block[sha256_pkg::chain_seed_word +: sha256_pkg::digest_words];
    end else if (busy & core_rsp.digest_valid) begin
      prev_q <= core_rsp.digest;
    end
  end

  // --------------------
  // Digest capture, SHA-224 drops the last word
  always_comb begin
    masked = core_rsp.digest;
    if (!cap_mode_q) begin
      masked[sha256_pkg::digest_words-1] = '0;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      digest     <= '0;
      valid_q    <= 1'b0;
      error_q    <= 1'b0;
      cap_mode_q <= 1'b1;
    end else if (ctrl.zeroize) begin
      digest  <= '0;
      valid_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      if (error_set) begin
        error_q <= 1'b1;
      end
      // A new command hides the old digest
      if (host_go | chain_go) begin
        valid_q    <= 1'b0;
        cap_mode_q <= ctrl.mode;
      end else if (done) begin
        digest  <= masked;
        valid_q <= 1'b1;
      end
    end
  end

  assign status.ready     = idle_ready;
  assign status.valid     = valid_q;
  assign status.wntz_busy = busy;
  assign status.error     = error_q;

endmodule

/* logic/sha256_regs.sv */
// SHA-256 register block
`timescale 1ns/1ps

module sha256_regs (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                cs,
  input  logic                                we,
  input  logic [sha256_pkg::addr_width-1:0]   address,
  input  logic [31:0]                         write_data,
  output logic [31:0]                         read_data,
  output logic                                err,
  output sha256_pkg::sha256_ctrl_t            ctrl,
  output sha256_pkg::sha256_wntz_t            wntz,
  output sha256_pkg::sha256_block_t           block,
  input  sha256_pkg::sha256_status_t          status,
  input  sha256_pkg::sha256_digest_t          digest
);

  localparam int wntz_bits = $bits(sha256_pkg::sha256_wntz_t);
  localparam int sts_bits  = $bits(sha256_pkg::sha256_status_t);
  localparam int aw        = sha256_pkg::addr_width;
  localparam int bib       = sha256_pkg::block_idx_bits;
  localparam int dib       = sha256_pkg::digest_idx_bits;

  logic block_sel;
  logic digest_sel;
  logic ctrl_sel;
  logic status_sel;
  logic wntz_sel;
  logic bad_access;
  logic wr_ok;
  logic bus_error_q;
  logic [31:0] rd_word;
  sha256_pkg::sha256_status_t sts_word;

  // --------------------
  // Address decode
  assign block_sel  = address[aw-1:bib] == sha256_pkg::addr_block_base[aw-1:bib];
  assign digest_sel = address[aw-1:dib] == sha256_pkg::addr_digest_base[aw-1:dib];
  assign ctrl_sel   = address == sha256_pkg::addr_ctrl;
  assign status_sel = address == sha256_pkg::addr_status;
  assign wntz_sel   = address == sha256_pkg::addr_wntz;

  // Unmapped, read only target, or any write during a chain
  assign bad_access = cs & (~(block_sel | digest_sel | ctrl_sel | status_sel | wntz_sel)
                      | (we & (status_sel | digest_sel))
                      | (we & status.wntz_busy));
  assign wr_ok      = cs & we & ~bad_access;

  // Bus errors show up in the status error bit as well
  always_comb begin
    sts_word       = status;
    sts_word.error = status.error | bus_error_q;
  end

  // --------------------
  // Read mux
  always_comb begin
    rd_word = '0;
    if (block_sel) begin
      rd_word = block[address[bib-1:0]];
    end else if (digest_sel) begin
      rd_word = digest[address[dib-1:0]];
    end else if (ctrl_sel) begin
      // Pulse bits always read back as zero
      rd_word[sha256_pkg::ctrl_mode_bit]      = ctrl.mode;
      rd_word[sha256_pkg::ctrl_wntz_mode_bit] = ctrl.wntz_mode;
      rd_word[sha256_pkg::ctrl_wntz_w_msb:sha256_pkg::ctrl_wntz_w_lsb] = ctrl.wntz_w;
    end else if (status_sel) begin
      rd_word[sts_bits-1:0] = sts_word;
    end else if (wntz_sel) begin
      rd_word[wntz_bits-1:0] = wntz;
    end
  end

  // --------------------
  // Registers
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ctrl        <= '0;
      wntz        <= '0;
      block       <= '0;
      read_data   <= '0;
      err         <= 1'b0;
      bus_error_q <= 1'b0;
    end else begin
      // Strobes last one cycle
      ctrl.init    <= 1'b0;
      ctrl.next    <= 1'b0;
      ctrl.zeroize <= 1'b0;
      err          <= bad_access;
      read_data    <= (cs & ~we) ? rd_word : '0;
      if (bad_access) begin
        bus_error_q <= 1'b1;
      end
      if (wr_ok & block_sel) begin
        block[address[bib-1:0]] <= write_data;
      end
      if (wr_ok & ctrl_sel) begin
        ctrl.init      <= write_data[sha256_pkg::ctrl_init_bit];
        ctrl.next      <= write_data[sha256_pkg::ctrl_next_bit];
        ctrl.mode      <= write_data[sha256_pkg::ctrl_mode_bit];
        ctrl.zeroize   <= write_data[sha256_pkg::ctrl_zeroize_bit];
        ctrl.wntz_mode <= write_data[sha256_pkg::ctrl_wntz_mode_bit];
        ctrl.wntz_w    <= write_data[sha256_pkg::ctrl_wntz_w_msb:sha256_pkg::ctrl_wntz_w_lsb];
      end
      if (wr_ok & wntz_sel) begin
        wntz <= write_data[wntz_bits-1:0];
      end
      // Zeroize wins over a block write in the same cycle
      if (ctrl.zeroize) begin
        block       <= '0;
        bus_error_q <= 1'b0;
      end
    end
  end

endmodule

/* logic/sha256_pkg.sv */
// SHA-256 accelerator shared types
package sha256_pkg;

  // --------------------
  // Sizes
  localparam int block_words  = 16;
  localparam int digest_words = 8;
  localparam int addr_width   = 6;

  // Index bits inside the block and digest windows
  localparam int block_idx_bits  = 4;
  localparam int digest_idx_bits = 3;

  // --------------------
  // Register map, word addresses
  localparam logic [addr_width-1:0] addr_block_base  = 6'h00;
  localparam logic [addr_width-1:0] addr_ctrl        = 6'h10;
  localparam logic [addr_width-1:0] addr_status      = 6'h11;
  localparam logic [addr_width-1:0] addr_wntz        = 6'h12;
  localparam logic [addr_width-1:0] addr_digest_base = 6'h18;

  // Control word bit positions
  localparam int ctrl_init_bit      = 0;
  localparam int ctrl_next_bit      = 1;
  localparam int ctrl_mode_bit      = 2;
  localparam int ctrl_zeroize_bit   = 3;
  localparam int ctrl_wntz_mode_bit = 4;
  localparam int ctrl_wntz_w_lsb    = 8;
  localparam int ctrl_wntz_w_msb    = 11;

  // Chain seed y sits in block words 8 to 15
  localparam int chain_seed_word = 8;
  // Chain message length in bits, I q i j and 32 byte digest
  localparam logic [63:0] chain_msg_bits = 64'd440;

  // --------------------
  // Core opcode and chain FSM states
  typedef enum logic [1:0] {cmd_none, cmd_init, cmd_next} sha256_cmd_e;
  typedef enum logic [1:0] {chain_idle, chain_first, chain_others} chain_state_e;

  // Decoded control, init next and zeroize are one cycle pulses
  typedef struct packed {
    logic       init;
    logic       next;
    logic       mode;
    logic       zeroize;
    logic       wntz_mode;
    logic [3:0] wntz_w;
  } sha256_ctrl_t;

  // Winternitz word, j_start in bits 23:16 and i in bits 15:0
  typedef struct packed {
    logic [7:0]  j_start;
    logic [15:0] i;
  } sha256_wntz_t;

  // Word 0 is the most significant word
  typedef logic [0:block_words-1][31:0]  sha256_block_t;
  typedef logic [0:digest_words-1][31:0] sha256_digest_t;

  typedef struct packed {
    sha256_cmd_e   cmd;
    logic          mode;
    sha256_block_t block;
  } sha256_core_req_t;

  typedef struct packed {
    logic           ready;
    logic           digest_valid;
    sha256_digest_t digest;
  } sha256_core_rsp_t;

  // Status word, ready in bit 0 up to error in bit 3
  typedef struct packed {
    logic error;
    logic wntz_busy;
    logic valid;
    logic ready;
  } sha256_status_t;

endpackage

/* include/sha256_k_table.svh */
// SHA-256 round constants
`ifndef SHA256_K_TABLE_SVH
`define SHA256_K_TABLE_SVH

// --------------------
// Round constants, K0 is the leftmost word
localparam logic [0:63][31:0] sha256_k = {
  32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
  32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
  32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
  32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
  32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
  32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
  32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
  32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
  32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
  32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
  32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
  32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
  32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
  32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
  32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
  32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

// --------------------
// Initial hash values, H0 is the leftmost word
localparam logic [0:7][31:0] sha256_iv = {
  32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
  32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
};

// SHA-224 uses its own start values
localparam logic [0:7][31:0] sha224_iv = {
  32'hc1059ed8, 32'h367cd507, 32'h3070dd17, 32'hf70e5939,
  32'hffc00b31, 32'h68581511, 32'h64f98fa7, 32'hbefa4fa4
};

`endif
